// ==== src/playfield_pkg.sv ====
package playfield_pkg;

   // ====================================================================
   // grid geometry
   // ====================================================================

   // playfield is 32 rows by 16 columns, row 0 at the top
   localparam int FIELD_ROWS = 32;
   localparam int FIELD_COLS = 16;

   // piece box, 4x4 cells
   localparam int PIECE_SIDE = 4;

   // top rows checked for game over
   localparam int SPAWN_ROWS = 4;

   // ====================================================================
   // index and row types
   // ====================================================================

   typedef logic [$clog2(FIELD_ROWS)-1:0] row_idx_t;
   typedef logic [$clog2(FIELD_COLS)-1:0] col_idx_t;

   // one grid row, bit c is column c
   typedef logic [FIELD_COLS-1:0] row_t;

   // piece bitmap, nibble k is piece row k
   // bit 0 of a nibble lands on the piece column
   typedef logic [PIECE_SIDE*PIECE_SIDE-1:0] shape_t;

   // read port word: fixed row in upper half, moving row in lower half
   typedef logic [2*FIELD_COLS-1:0] pair_t;

   // one mask per piece row
   typedef row_t [PIECE_SIDE-1:0] span_t;

   // whole grid, index is the row
   typedef row_t [FIELD_ROWS-1:0] field_t;

   // rows removed in one step, 0 to 4 in normal play
   typedef logic [2:0] clear_cnt_t;

endpackage

// ==== src/block_raster.sv ====
module block_raster (
   input  playfield_pkg::row_idx_t row,
   input  playfield_pkg::col_idx_t col,
   input  playfield_pkg::shape_t   shape,
   output playfield_pkg::span_t    span,
   output logic                    clipped
);

   import playfield_pkg::*;

   // ====================================================================
   // column placement of each shape nibble
   // ====================================================================

   // extra room so bits pushed past column 15 stay visible
   localparam int EXT_W = FIELD_COLS + PIECE_SIDE;

   // per piece row: some cell fell off the right edge
   logic [PIECE_SIDE-1:0] clip_row;

   for (genvar k = 0; k < PIECE_SIDE; k++) begin : g_nib
      // widened nibble after the column shift
      logic [EXT_W-1:0] ext;

      assign ext = EXT_W'(shape[k*PIECE_SIDE +: PIECE_SIDE]) << col;

      // visible part goes out as the grid-aligned mask
      assign span[k] = ext[FIELD_COLS-1:0];

      // anything above the visible part is a clip
      assign clip_row[k] = |ext[EXT_W-1:FIELD_COLS];
   end

   // one clipped row is enough to reject the placement
   assign clipped = |clip_row;

   // ====================================================================
   // row sanity
   // ====================================================================

   // row placement happens downstream in the probes and the store
   // only the anchor row is checked here
   always_comb begin
      if (!$isunknown(row)) begin
         row_in_range: assert (int'(row) < FIELD_ROWS)
            else $error("block_raster: anchor row %0d outside the grid", row);
      end
   end

endmodule

// ==== src/field_probe.sv ====
module field_probe #(
   parameter int unsigned ROW_OFFSET = 0
) (
   input  playfield_pkg::row_idx_t row,
   input  playfield_pkg::span_t    span,
   input  logic                    clipped,
   input  playfield_pkg::field_t   field,
   output logic                    hit
);

   import playfield_pkg::*;

   // ====================================================================
   // target row arithmetic
   // ====================================================================

   // index width of the grid
   localparam int ROW_W = $bits(row_idx_t);

   // wide enough for row + 3 + offset, never wraps
   localparam int TGT_W = $clog2(FIELD_ROWS + PIECE_SIDE + ROW_OFFSET) + 1;

   // per piece row collision result
   logic [PIECE_SIDE-1:0] row_hit;

   for (genvar k = 0; k < PIECE_SIDE; k++) begin : g_row
      // fixed distance from the anchor row
      localparam int unsigned ADD = k + ROW_OFFSET;

      // grid row that mask k lands on
      logic [TGT_W-1:0] tgt;
      // mask k has at least one cell
      logic             occupied;
      // target below the floor
      logic             past_floor;
      // target overlaps a fixed cell
      logic             overlap;

      assign tgt        = TGT_W'(row) + TGT_W'(ADD);
      assign occupied   = (span[k] != '0);
      assign past_floor = (int'(tgt) >= FIELD_ROWS);

      // index only meaningful when past_floor is low
      assign overlap    = |(span[k] & field[tgt[ROW_W-1:0]]);

      // empty masks never collide, even below the floor
      assign row_hit[k] = occupied && (past_floor || overlap);
   end

   // ====================================================================
   // result
   // ====================================================================

   // clipped piece counts as a hit whatever the rows say
   // offset 1: cannot drop, offset 0: does not fit
   assign hit = clipped || (|row_hit);

endmodule

// ==== src/line_clear.sv ====
module line_clear (
   input  playfield_pkg::field_t     field_in,
   output playfield_pkg::field_t     field_out,
   output playfield_pkg::clear_cnt_t count
);

   import playfield_pkg::*;

   // ====================================================================
   // bottom-up compaction
   // ====================================================================

   // largest value the count port can show
   localparam int CNT_MAX = (1 << $bits(clear_cnt_t)) - 1;

   always_comb begin
      // next free row from the bottom
      int wr;
      // full rows seen so far
      int cnt;

      // rows not refilled stay empty at the top
      field_out = '0;
      wr        = FIELD_ROWS - 1;
      cnt       = 0;

      // walk up from the floor
      for (int r = FIELD_ROWS - 1; r >= 0; r--) begin
         if (field_in[r] == '1) begin
            // full row, drop it
            cnt = cnt + 1;
         end else begin
            // keep it, packed onto the lowest free row
            field_out[wr] = field_in[r];
            wr            = wr - 1;
         end
      end

      // saturate, a legal grid never reaches this
      if (cnt > CNT_MAX) begin
         count = clear_cnt_t'(CNT_MAX);
      end else begin
         count = clear_cnt_t'(cnt);
      end
   end

endmodule

// ==== src/playfield_store.sv ====
module playfield_store (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      step,
   input  playfield_pkg::row_idx_t   mv_row,
   input  playfield_pkg::span_t      mv_span,
   input  logic                      land_hit,
   input  logic                      fit_hit,
   input  playfield_pkg::row_idx_t   rd1_row,
   input  playfield_pkg::row_idx_t   rd2_row,
   output playfield_pkg::field_t     field,
   output logic                      mv_down_enable,
   output logic                      tst_overlap,
   output logic                      game_over,
   output playfield_pkg::pair_t      rd1_data,
   output playfield_pkg::pair_t      rd2_data,
   output playfield_pkg::clear_cnt_t cleared
);

   import playfield_pkg::*;

   localparam int ROW_W = $bits(row_idx_t);

   // moving piece spread over the whole grid
   field_t     mv_layer;
   // grid with the landed piece locked in
   field_t     merged;
   // merge after full rows are gone
   field_t     compacted;
   // rows removed by this step
   clear_cnt_t clear_count;
   // fixed rows with every cell set
   logic [FIELD_ROWS-1:0] row_full;

   // ====================================================================
   // moving layer
   // ====================================================================

   always_comb begin
      // piece row index, one bit wider to catch the floor
      logic [ROW_W:0] tgt;

      mv_layer = '0;
      for (int k = 0; k < PIECE_SIDE; k++) begin
         tgt = {1'b0, mv_row} + (ROW_W + 1)'(k);
         // rows past the bottom are not drawn
         if (int'(tgt) < FIELD_ROWS) begin
            mv_layer[tgt[ROW_W-1:0]] = mv_span[k];
         end
      end
   end

   // ====================================================================
   // lock and clear
   // ====================================================================

   // lock only a piece that cannot drop any further
   assign merged = land_hit ? (field | mv_layer) : field;

   line_clear u_clear (
      .field_in  (merged),
      .field_out (compacted),
      .count     (clear_count)
   );

   // grid and count only move on a step
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         field   <= '0;
         cleared <= '0;
      end else if (step) begin
         field   <= compacted;
         cleared <= clear_count;
      end
   end

   // flags, one cycle behind the inputs
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         mv_down_enable <= 1'b1;
         tst_overlap    <= 1'b0;
      end else begin
         mv_down_enable <= ~land_hit;
         tst_overlap    <= fit_hit;
      end
   end

   // ====================================================================
   // read ports and game over
   // ====================================================================

   assign rd1_data = {field[rd1_row], mv_layer[rd1_row]};
   assign rd2_data = {field[rd2_row], mv_layer[rd2_row]};

   // piece sitting on locked cells inside the spawn zone
   always_comb begin
      game_over = 1'b0;
      for (int r = 0; r < SPAWN_ROWS; r++) begin
         game_over = game_over | (|(field[r] & mv_layer[r]));
      end
   end

   // ====================================================================
   // checks
   // ====================================================================

   for (genvar r = 0; r < FIELD_ROWS; r++) begin : g_full
      assign row_full[r] = &field[r];
   end

   // one piece spans four rows, so no step can clear more
   step_clear_max: assert property (@(posedge clk) disable iff (!rstn)
      step |=> (cleared <= clear_cnt_t'(PIECE_SIDE)));

   // line_clear must leave no full row behind in the stored grid
   no_full_row: assert property (@(posedge clk) disable iff (!rstn)
      row_full == '0);

endmodule

// ==== src/playfield_top.sv ====
module playfield_top (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      step,
   input  playfield_pkg::row_idx_t   mv_row,
   input  playfield_pkg::col_idx_t   mv_col,
   input  playfield_pkg::shape_t     mv_shape,
   input  playfield_pkg::row_idx_t   tst_row,
   input  playfield_pkg::col_idx_t   tst_col,
   input  playfield_pkg::shape_t     tst_shape,
   input  playfield_pkg::row_idx_t   rd1_row,
   input  playfield_pkg::row_idx_t   rd2_row,
   output logic                      mv_down_enable,
   output logic                      tst_overlap,
   output logic                      game_over,
   output playfield_pkg::pair_t      rd1_data,
   output playfield_pkg::pair_t      rd2_data,
   output playfield_pkg::clear_cnt_t cleared
);

   import playfield_pkg::*;

   // ====================================================================
   // rasterized pieces
   // ====================================================================

   span_t  mv_span;
   logic   mv_clip;
   span_t  tst_span;
   logic   tst_clip;

   // probe results
   logic   land_hit;
   logic   fit_hit;

   // fixed grid fed back from the store
   field_t field;

   block_raster u_mv_raster (
      .row     (mv_row),
      .col     (mv_col),
      .shape   (mv_shape),
      .span    (mv_span),
      .clipped (mv_clip)
   );

   block_raster u_tst_raster (
      .row     (tst_row),
      .col     (tst_col),
      .shape   (tst_shape),
      .span    (tst_span),
      .clipped (tst_clip)
   );

   // ====================================================================
   // probes
   // ====================================================================

   // one row lower: has the moving piece landed
   field_probe #(.ROW_OFFSET(1)) u_land (
      .row     (mv_row),
      .span    (mv_span),
      .clipped (mv_clip),
      .field   (field),
      .hit     (land_hit)
   );

   // in place: does the test piece collide
   field_probe #(.ROW_OFFSET(0)) u_fit (
      .row     (tst_row),
      .span    (tst_span),
      .clipped (tst_clip),
      .field   (field),
      .hit     (fit_hit)
   );

   // ====================================================================
   // grid storage
   // ====================================================================

   playfield_store u_store (
      .clk            (clk),
      .rstn           (rstn),
      .step           (step),
      .mv_row         (mv_row),
      .mv_span        (mv_span),
      .land_hit       (land_hit),
      .fit_hit        (fit_hit),
      .rd1_row        (rd1_row),
      .rd2_row        (rd2_row),
      .field          (field),
      .mv_down_enable (mv_down_enable),
      .tst_overlap    (tst_overlap),
      .game_over      (game_over),
      .rd1_data       (rd1_data),
      .rd2_data       (rd2_data),
      .cleared        (cleared)
   );

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
   output logic clk,
   output logic rstn
);

   timeunit 1ns;
   timeprecision 100ps;

   // 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // reset low for 4 rising edges, released in the stimulus slot
   initial begin
      rstn = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      rstn = 1'b1;
   end

endmodule

// ==== testbench/tb_playfield.sv ====
module tb_playfield;

   timeunit 1ns;
   timeprecision 100ps;

   import playfield_pkg::*;

   logic clk, rstn, step;
   row_idx_t mv_row, tst_row, rd1_row, rd2_row;
   col_idx_t mv_col, tst_col;
   shape_t mv_shape, tst_shape;
   logic mv_down_enable, tst_overlap, game_over;
   pair_t rd1_data, rd2_data;
   clear_cnt_t cleared;

   // reference grid and last clear count
   field_t mdl_field;
   clear_cnt_t mdl_cleared;
   int seed = 32'hb5a6;
   int n_checks = 0;
   int n_errors = 0;
   int go_seen = 0;
   shape_t shapes [7];
   logic reset_ok;

   tb_clock u_clock (.clk(clk), .rstn(rstn));

   playfield_top DUT (
      .clk(clk), .rstn(rstn), .step(step),
      .mv_row(mv_row), .mv_col(mv_col), .mv_shape(mv_shape),
      .tst_row(tst_row), .tst_col(tst_col), .tst_shape(tst_shape),
      .rd1_row(rd1_row), .rd2_row(rd2_row),
      .mv_down_enable(mv_down_enable), .tst_overlap(tst_overlap),
      .game_over(game_over), .rd1_data(rd1_data), .rd2_data(rd2_data),
      .cleared(cleared)
   );

   // ======================================================================
   // compare tasks
   // ======================================================================

   task automatic check_pair(string name, pair_t got, pair_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_count(string name, clear_cnt_t got, clear_cnt_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // ======================================================================
   // reference model
   // ======================================================================

   // cells of piece row k that stay on the grid, one at a time
   function automatic row_t piece_row(shape_t s, col_idx_t col, int k);
      row_t m;
      m = '0;
      for (int j = 0; j < PIECE_SIDE; j++) begin
         if (s[PIECE_SIDE*k+j] && int'(col) + j < FIELD_COLS) begin
            m[int'(col)+j] = 1'b1;
         end
      end
      return m;
   endfunction

   // any cell past the right wall
   function automatic logic piece_clipped(shape_t s, col_idx_t col);
      for (int k = 0; k < PIECE_SIDE; k++) begin
         for (int j = 0; j < PIECE_SIDE; j++) begin
            if (s[PIECE_SIDE*k+j] && int'(col) + j >= FIELD_COLS) begin
               return 1'b1;
            end
         end
      end
      return 1'b0;
   endfunction

   // collision against wall, floor and locked cells, shifted down by off
   function automatic logic piece_hits(row_idx_t row, col_idx_t col, shape_t s, int off);
      row_t m;
      int t;
      if (piece_clipped(s, col)) begin
         return 1'b1;
      end
      for (int k = 0; k < PIECE_SIDE; k++) begin
         m = piece_row(s, col, k);
         t = int'(row) + k + off;
         if (m != '0) begin
            if (t >= FIELD_ROWS) begin
               return 1'b1;
            end
            if ((m & mdl_field[t]) != '0) begin
               return 1'b1;
            end
         end
      end
      return 1'b0;
   endfunction

   // moving piece drawn on an empty grid, bottom rows cut off
   function automatic field_t piece_layer(row_idx_t row, col_idx_t col, shape_t s);
      field_t l;
      l = '0;
      for (int k = 0; k < PIECE_SIDE; k++) begin
         if (int'(row) + k < FIELD_ROWS) begin
            l[int'(row)+k] = piece_row(s, col, k);
         end
      end
      return l;
   endfunction

   // lock if landed, then collapse full rows one by one
   task automatic model_step(row_idx_t row, col_idx_t col, shape_t s);
      field_t g;
      int r;
      int n;
      g = mdl_field;
      n = 0;
      if (piece_hits(row, col, s, 1)) begin
         g = g | piece_layer(row, col, s);
      end
      r = FIELD_ROWS - 1;
      while (r >= 0) begin
         if (g[r] == {FIELD_COLS{1'b1}}) begin
            // everything above slides one row down
            for (int i = r; i > 0; i--) begin
               g[i] = g[i-1];
            end
            g[0] = '0;
            n++;
         end else begin
            r--;
         end
      end
      mdl_field = g;
      mdl_cleared = clear_cnt_t'(n);
   endtask

   // ======================================================================
   // one clock cycle of stimulus and checks
   // ======================================================================

   // called 2 ns after a rising edge, returns 2 ns after the next one
   task automatic run_cycle(row_idx_t m_row, col_idx_t m_col, shape_t m_shp,
                            row_idx_t t_row, col_idx_t t_col, shape_t t_shp,
                            row_idx_t r1, row_idx_t r2, logic stp);
      field_t lay;
      logic exp_down;
      logic exp_ovl;
      logic exp_go;
      mv_row = m_row;
      mv_col = m_col;
      mv_shape = m_shp;
      tst_row = t_row;
      tst_col = t_col;
      tst_shape = t_shp;
      rd1_row = r1;
      rd2_row = r2;
      step = stp;
      // expectations from the grid before the edge
      lay = piece_layer(m_row, m_col, m_shp);
      exp_down = ~piece_hits(m_row, m_col, m_shp, 1);
      exp_ovl = piece_hits(t_row, t_col, t_shp, 0);
      exp_go = 1'b0;
      for (int r = 0; r < SPAWN_ROWS; r++) begin
         if ((mdl_field[r] & lay[r]) != '0) begin
            exp_go = 1'b1;
         end
      end
      if (exp_go) begin
         go_seen++;
      end
      // combinational outputs, well settled mid cycle
      #8;
      check_pair("rd1_data", rd1_data, {mdl_field[r1], lay[r1]});
      check_pair("rd2_data", rd2_data, {mdl_field[r2], lay[r2]});
      check_flag("game_over", game_over, exp_go);
      @(posedge clk);
      #1;
      if (stp) begin
         model_step(m_row, m_col, m_shp);
      end
      // registered flags, one cycle latency
      check_flag("mv_down_enable", mv_down_enable, exp_down);
      check_flag("tst_overlap", tst_overlap, exp_ovl);
      check_count("cleared", cleared, mdl_cleared);
      #1;
   endtask

   task automatic random_cycle(int step_pct);
      row_idx_t mr;
      row_idx_t tr;
      col_idx_t mc;
      col_idx_t tc;
      shape_t ms;
      shape_t ts;
      row_idx_t r1;
      row_idx_t r2;
      logic st;
      mr = row_idx_t'($random(seed));
      mc = col_idx_t'($random(seed));
      ms = shapes[$unsigned($random(seed)) % 7];
      tr = row_idx_t'($random(seed));
      tc = col_idx_t'($random(seed));
      ts = shapes[$unsigned($random(seed)) % 7];
      r1 = row_idx_t'($random(seed));
      r2 = row_idx_t'($random(seed));
      st = ($unsigned($random(seed)) % 100) < step_pct;
      run_cycle(mr, mc, ms, tr, tc, ts, r1, r2, st);
   endtask

   // reset release, bounded by a cycle count
   // returns on the falling edge after release, before any clocked update
   task automatic wait_reset(output logic ok);
      int n;
      n = 0;
      while (rstn !== 1'b1 && n < 20) begin
         @(negedge clk);
         n++;
      end
      ok = (rstn === 1'b1);
   endtask

   // ======================================================================
   // main sequence
   // ======================================================================

   initial begin
      // spawn orientation tetrominoes: I O T S Z J L
      shapes[0] = 16'h000F;
      shapes[1] = 16'h0033;
      shapes[2] = 16'h0027;
      shapes[3] = 16'h0036;
      shapes[4] = 16'h0063;
      shapes[5] = 16'h0071;
      shapes[6] = 16'h0074;
      mdl_field = '0;
      mdl_cleared = '0;
      step = 1'b0;
      mv_row = '0;
      mv_col = '0;
      mv_shape = '0;
      tst_row = '0;
      tst_col = '0;
      tst_shape = '0;
      rd1_row = '0;
      rd2_row = '0;
      wait_reset(reset_ok);
      if (!reset_ok) begin
         n_errors++;
         $display("reset was never released within 20 clock cycles");
      end else begin
         // reset values, no rising edge since the release
         check_flag("mv_down_enable", mv_down_enable, 1'b1);
         check_flag("tst_overlap", tst_overlap, 1'b0);
         check_count("cleared", cleared, '0);
         // first stimulus slot after the release
         @(posedge clk);
         #2;
         // empty grid on every row
         for (int r = 0; r < FIELD_ROWS; r += 2) begin
            run_cycle('0, '0, '0, '0, '0, '0, row_idx_t'(r), row_idx_t'(r + 1), 1'b0);
         end
         // two I pieces on the floor, an O resting on them, two more I pieces
         run_cycle(5'd31, 4'd0, shapes[0], '0, '0, '0, 5'd31, 5'd30, 1'b1);
         run_cycle(5'd31, 4'd4, shapes[0], '0, '0, '0, 5'd31, 5'd30, 1'b1);
         run_cycle(5'd29, 4'd0, shapes[1], 5'd30, 4'd0, shapes[1], 5'd31, 5'd30, 1'b1);
         run_cycle(5'd31, 4'd8, shapes[0], 5'd31, 4'd8, shapes[0], 5'd31, 5'd30, 1'b1);
         run_cycle(5'd31, 4'd12, shapes[0], '0, '0, '0, 5'd31, 5'd30, 1'b1);
         run_cycle('0, '0, '0, '0, '0, '0, 5'd31, 5'd30, 1'b0);
         // bottom row gone, the O dropped one row onto rows 30 and 31
         check_count("cleared", cleared, 3'd1);
         check_pair("rd1_data", rd1_data, {16'h0003, 16'h0000});
         check_pair("rd2_data", rd2_data, {16'h0003, 16'h0000});
         // random play against the model
         for (int i = 0; i < 600; i++) begin
            random_cycle(50);
         end
         // spawn zone collisions must have come up at least once
         if (go_seen == 0) begin
            n_errors++;
            $display("random play never put a moving piece on locked cells in rows 0 to 3");
         end
      end
      $display("summary: %0d checks, %0d errors, %0d game over cycles",
               n_checks, n_errors, go_seen);
      if (n_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
src/playfield_pkg.sv
src/block_raster.sv
src/field_probe.sv
src/line_clear.sv
src/playfield_store.sv
src/playfield_top.sv
testbench/tb_clock.sv
testbench/tb_playfield.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the playfield testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --timescale 1ns/100ps \
   --top-module tb_playfield \
   -f vlog.f \
   -o sim_playfield

./obj_dir/sim_playfield > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
